// File: Makefile
VERILATOR ?= verilator
FLAGS ?= --binary -j 0 -Wall
TOP ?= tb_simple_fixed_unit
FILELIST ?= tb.f
LOG ?= sim.log
PASS_MSG = Test OK

OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: fixed_config.svh
`ifndef FIXED_CONFIG_SVH
`define FIXED_CONFIG_SVH

// datapath and field widths
`define FX_QUAD_W 128
`define FX_OPC_W 11
`define FX_FMT_W 3
`define FX_ADDR_W 7
`define FX_IMM_W 18
// only the low 10 bits of imm carry the RI10 immediate
`define FX_IMM10_W 10

// instruction formats handled by this unit
`define FX_FMT_RR 3'd0
`define FX_FMT_RI10 3'd4

// register-register opcodes, full 11-bit op field
`define FX_OPC_AH 11'b00011001000
`define FX_OPC_A 11'b00011000000
`define FX_OPC_SFH 11'b00001001000
`define FX_OPC_SF 11'b00001000000
`define FX_OPC_AND 11'b00011000001
`define FX_OPC_OR 11'b00001000001
`define FX_OPC_XOR 11'b01001000001
`define FX_OPC_NAND 11'b00011001001
// compares, byte / halfword / word
`define FX_OPC_CEQB 11'b01111010000
`define FX_OPC_CEQH 11'b01111001000
`define FX_OPC_CEQ 11'b01111000000
`define FX_OPC_CGTB 11'b01001010000
`define FX_OPC_CGTH 11'b01001001000
`define FX_OPC_CGT 11'b01001000000
`define FX_OPC_CLGTB 11'b01011010000
`define FX_OPC_CLGTH 11'b01011001000
`define FX_OPC_CLGT 11'b01011000000

// RI10 opcodes are 8 bits wide
// they arrive zero-extended in the low end of the op field
`define FX_OPC_AHI 8'b00011101
`define FX_OPC_AI 8'b00011100
`define FX_OPC_SFHI 8'b00001101
`define FX_OPC_SFI 8'b00001100
`define FX_OPC_ANDHI 8'b00010101
`define FX_OPC_ANDI 8'b00010100
`define FX_OPC_ORHI 8'b00000101
`define FX_OPC_ORI 8'b00000100
`define FX_OPC_XORHI 8'b01000101
`define FX_OPC_XORI 8'b01000100
// immediate compares
`define FX_OPC_CEQBI 8'b01111110
`define FX_OPC_CEQHI 8'b01111101
`define FX_OPC_CEQI 8'b01111100
`define FX_OPC_CGTBI 8'b01001110
`define FX_OPC_CGTHI 8'b01001101
`define FX_OPC_CGTI 8'b01001100
`define FX_OPC_CLGTBI 8'b01011110
`define FX_OPC_CLGTHI 8'b01011101
`define FX_OPC_CLGTI 8'b01011100

`endif

// File: fixed_lane_alu.sv
module fixed_lane_alu
	import fixed_pkg::*;
(
	input fx_op_e fx_op,
	input elem_size_e elem_size,
	input quad_t ra,
	input quad_t operand_b,
	output quad_t result
);

	// one element of any size, value right aligned in a 32-bit slot
	// bits above the element size are ignored on the way in and zero on the way out
	function automatic logic [31:0] elem_calc(
		input fx_op_e op,
		input elem_size_e size,
		input logic [31:0] a,
		input logic [31:0] b
	);
		logic [31:0] mask;
		logic [31:0] sign_bit;
		logic [31:0] ua;
		logic [31:0] ub;
		logic [31:0] sa;
		logic [31:0] sb;
		logic [31:0] smax;
		logic [31:0] smin;
		logic [31:0] sum;
		logic [31:0] diff;
		logic a_neg;
		logic b_neg;
		logic sum_neg;
		logic diff_neg;
		logic add_ovf;
		logic sub_ovf;
		logic [31:0] r;

		case (size)
			ES_BYTE: mask = 32'h0000_00ff;
			ES_HALF: mask = 32'h0000_ffff;
			default: mask = 32'hffff_ffff;
		endcase
		// top bit of the element
		sign_bit = mask ^ (mask >> 1);

		ua = a & mask;
		ub = b & mask;
		a_neg = |(ua & sign_bit);
		b_neg = |(ub & sign_bit);
		// sign extend to the full slot for the signed compare
		sa = a_neg ? (ua | ~mask) : ua;
		sb = b_neg ? (ub | ~mask) : ub;

		// signed limits, smin kept sign extended so it masks down cleanly
		smax = mask >> 1;
		smin = ~smax;

		// low bits of the wrapped sums are the element-width result
		sum = sa + sb;
		diff = sb - sa;
		sum_neg = |(sum & sign_bit);
		diff_neg = |(diff & sign_bit);

		// add overflows only with like signs and a flipped result sign
		add_ovf = (a_neg == b_neg) && (sum_neg != a_neg);
		// b - a overflows only with unlike signs, result must follow b
		sub_ovf = (a_neg != b_neg) && (diff_neg != b_neg);

		case (op)
			FX_ADD: r = add_ovf ? (a_neg ? smin : smax) : sum;
			FX_SUB_FROM: r = sub_ovf ? (b_neg ? smin : smax) : diff;
			FX_AND: r = ua & ub;
			FX_OR: r = ua | ub;
			FX_XOR: r = ua ^ ub;
			FX_NAND: r = ~(ua & ub);
			FX_CEQ: r = {32{ua == ub}};
			FX_CGT: r = {32{$signed(sa) > $signed(sb)}};
			FX_CLGT: r = {32{ua > ub}};
			// squashed slot, nothing to write
			default: r = '0;
		endcase

		return r & mask;
	endfunction

	always_comb begin
		logic [31:0] lane;

		result = '0;
		lane = '0;
		case (elem_size)
			// 16 byte elements
			ES_BYTE: begin
				for (int i = 0; i < $bits(quad_t) / 8; i++) begin
					lane = elem_calc(fx_op, elem_size, {24'b0, ra[i*8 +: 8]},
						{24'b0, operand_b[i*8 +: 8]});
					result[i*8 +: 8] = lane[7:0];
				end
			end
			// 8 halfword elements
			ES_HALF: begin
				for (int i = 0; i < $bits(quad_t) / 16; i++) begin
					lane = elem_calc(fx_op, elem_size, {16'b0, ra[i*16 +: 16]},
						{16'b0, operand_b[i*16 +: 16]});
					result[i*16 +: 16] = lane[15:0];
				end
			end
			// 4 word elements
			default: begin
				for (int i = 0; i < $bits(quad_t) / 32; i++) begin
					lane = elem_calc(fx_op, elem_size, ra[i*32 +: 32],
						operand_b[i*32 +: 32]);
					result[i*32 +: 32] = lane;
				end
			end
		endcase
	end

endmodule

// File: fixed_operand_decode.sv
`include "fixed_config.svh"

module fixed_operand_decode
	import fixed_pkg::*;
(
	input logic [`FX_FMT_W-1:0] format,
	input logic [0:`FX_OPC_W-1] op,
	input reg_addr_t rt_addr,
	input quad_t rb,
	input logic [0:`FX_IMM_W-1] imm,
	input logic reg_write,
	input logic branch_taken,
	output fx_op_e fx_op,
	output elem_size_e elem_size,
	output quad_t operand_b,
	output reg_addr_t dest_addr,
	output logic dest_write
);

	fx_op_e rr_op;
	fx_op_e ri_op;
	elem_size_e rr_size;
	elem_size_e ri_size;
	// RI10 opcode is the low 8 bits, the rest of op must be zero
	logic [0:7] ri_opc;
	logic ri_upper_zero;
	logic is_rr;
	logic is_ri10;
	logic slot_ok;
	logic squash;
	// immediate at each element size
	logic [0:`FX_IMM10_W-1] imm10;
	logic [0:7] imm8;
	logic [0:15] imm_half;
	logic [0:31] imm_word;
	quad_t imm_quad;

	assign ri_opc = op[`FX_OPC_W-8:`FX_OPC_W-1];
	assign ri_upper_zero = (op[0:`FX_OPC_W-9] == '0);
	assign is_rr = (format == `FX_FMT_RR);
	assign is_ri10 = (format == `FX_FMT_RI10) && ri_upper_zero;

	// format 0 operation, op 0 (nop) and unknown codes fall to FX_NOP
	always_comb begin
		case (op)
			`FX_OPC_AH, `FX_OPC_A: rr_op = FX_ADD;
			`FX_OPC_SFH, `FX_OPC_SF: rr_op = FX_SUB_FROM;
			`FX_OPC_AND: rr_op = FX_AND;
			`FX_OPC_OR: rr_op = FX_OR;
			`FX_OPC_XOR: rr_op = FX_XOR;
			`FX_OPC_NAND: rr_op = FX_NAND;
			`FX_OPC_CEQB, `FX_OPC_CEQH, `FX_OPC_CEQ: rr_op = FX_CEQ;
			`FX_OPC_CGTB, `FX_OPC_CGTH, `FX_OPC_CGT: rr_op = FX_CGT;
			`FX_OPC_CLGTB, `FX_OPC_CLGTH, `FX_OPC_CLGT: rr_op = FX_CLGT;
			default: rr_op = FX_NOP;
		endcase
	end

	// format 0 element size, logic ops don't care and take word
	always_comb begin
		case (op)
			`FX_OPC_CEQB, `FX_OPC_CGTB, `FX_OPC_CLGTB: rr_size = ES_BYTE;
			`FX_OPC_AH, `FX_OPC_SFH, `FX_OPC_CEQH, `FX_OPC_CGTH,
			`FX_OPC_CLGTH: rr_size = ES_HALF;
			default: rr_size = ES_WORD;
		endcase
	end

	// format 4 operation
	always_comb begin
		case (ri_opc)
			`FX_OPC_AHI, `FX_OPC_AI: ri_op = FX_ADD;
			`FX_OPC_SFHI, `FX_OPC_SFI: ri_op = FX_SUB_FROM;
			`FX_OPC_ANDHI, `FX_OPC_ANDI: ri_op = FX_AND;
			`FX_OPC_ORHI, `FX_OPC_ORI: ri_op = FX_OR;
			`FX_OPC_XORHI, `FX_OPC_XORI: ri_op = FX_XOR;
			`FX_OPC_CEQBI, `FX_OPC_CEQHI, `FX_OPC_CEQI: ri_op = FX_CEQ;
			`FX_OPC_CGTBI, `FX_OPC_CGTHI, `FX_OPC_CGTI: ri_op = FX_CGT;
			`FX_OPC_CLGTBI, `FX_OPC_CLGTHI, `FX_OPC_CLGTI: ri_op = FX_CLGT;
			default: ri_op = FX_NOP;
		endcase
	end

	// format 4 element size, this also sets the immediate replication
	always_comb begin
		case (ri_opc)
			`FX_OPC_CEQBI, `FX_OPC_CGTBI, `FX_OPC_CLGTBI: ri_size = ES_BYTE;
			`FX_OPC_AHI, `FX_OPC_SFHI, `FX_OPC_ANDHI, `FX_OPC_ORHI, `FX_OPC_XORHI,
			`FX_OPC_CEQHI, `FX_OPC_CGTHI, `FX_OPC_CLGTHI: ri_size = ES_HALF;
			default: ri_size = ES_WORD;
		endcase
	end

	// sign extension of imm10, byte forms just take the low 8 bits
	assign imm10 = imm[`FX_IMM_W-`FX_IMM10_W:`FX_IMM_W-1];
	assign imm8 = imm10[`FX_IMM10_W-8:`FX_IMM10_W-1];
	assign imm_half = {{(16-`FX_IMM10_W){imm10[0]}}, imm10};
	assign imm_word = {{(32-`FX_IMM10_W){imm10[0]}}, imm10};

	always_comb begin
		case (ri_size)
			ES_BYTE: imm_quad = {($bits(quad_t)/8){imm8}};
			ES_HALF: imm_quad = {($bits(quad_t)/16){imm_half}};
			default: imm_quad = {($bits(quad_t)/32){imm_word}};
		endcase
	end

	// a slot is live only for a known opcode in a known format
	assign slot_ok = (is_rr && (rr_op != FX_NOP)) || (is_ri10 && (ri_op != FX_NOP));
	// taken branch kills the slot regardless of the opcode
	assign squash = branch_taken || !slot_ok;

	always_comb begin
		if (squash) begin
			fx_op = FX_NOP;
		end else if (is_rr) begin
			fx_op = rr_op;
		end else begin
			fx_op = ri_op;
		end
	end

	always_comb begin
		if (is_rr) begin
			elem_size = rr_size;
		end else begin
			elem_size = ri_size;
		end
	end

	assign operand_b = is_rr ? rb : imm_quad;
	assign dest_addr = squash ? '0 : rt_addr;
	assign dest_write = reg_write && !squash;

endmodule

// File: fixed_pkg.sv
`include "fixed_config.svh"

package fixed_pkg;

	// one register value, element 0 sits at bit 0 (the msb end)
	typedef logic [0:`FX_QUAD_W-1] quad_t;

	// register file address
	typedef logic [0:`FX_ADDR_W-1] reg_addr_t;

	// decoded operation, FX_NOP also marks a squashed slot
	typedef enum logic [3:0] {
		FX_NOP,
		FX_ADD,
		FX_SUB_FROM,
		FX_AND,
		FX_OR,
		FX_XOR,
		FX_NAND,
		FX_CEQ,
		FX_CGT,
		FX_CLGT
	} fx_op_e;

	// element size, 16 / 8 / 4 elements per quadword
	typedef enum logic [1:0] {
		ES_BYTE,
		ES_HALF,
		ES_WORD
	} elem_size_e;

endpackage

// File: fixed_result_stage.sv
module fixed_result_stage
	import fixed_pkg::*;
(
	input logic clk,
	input logic reset,
	input quad_t result,
	input reg_addr_t dest_addr,
	input logic dest_write,
	output quad_t rt_wb,
	output reg_addr_t rt_addr_wb,
	output logic reg_write_wb
);

	// first stage, holds the instruction issued last cycle
	quad_t value_s1;
	reg_addr_t addr_s1;
	logic write_s1;

	// both stages shift every cycle, there is no stall
	always_ff @(posedge clk) begin
		if (reset) begin
			value_s1 <= '0;
			addr_s1 <= '0;
			write_s1 <= 1'b0;
			rt_wb <= '0;
			rt_addr_wb <= '0;
			reg_write_wb <= 1'b0;
		end else begin
			value_s1 <= result;
			addr_s1 <= dest_addr;
			write_s1 <= dest_write;
			// second stage feeds writeback directly
			rt_wb <= value_s1;
			rt_addr_wb <= addr_s1;
			reg_write_wb <= write_s1;
		end
	end

endmodule

// File: simple_fixed_unit.sv
`include "fixed_config.svh"

module simple_fixed_unit
	import fixed_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [`FX_FMT_W-1:0] format,
	input logic [0:`FX_OPC_W-1] op,
	input reg_addr_t rt_addr,
	input quad_t ra,
	input quad_t rb,
	input logic [0:`FX_IMM_W-1] imm,
	input logic reg_write,
	input logic branch_taken,
	output quad_t rt_wb,
	output reg_addr_t rt_addr_wb,
	output logic reg_write_wb
);

	// decode to alu
	fx_op_e fx_op;
	elem_size_e elem_size;
	quad_t operand_b;
	// alu and decode to the staging pipe
	quad_t result;
	reg_addr_t dest_addr;
	logic dest_write;

	fixed_operand_decode decode_i (
		.format(format),
		.op(op),
		.rt_addr(rt_addr),
		.rb(rb),
		.imm(imm),
		.reg_write(reg_write),
		.branch_taken(branch_taken),
		.fx_op(fx_op),
		.elem_size(elem_size),
		.operand_b(operand_b),
		.dest_addr(dest_addr),
		.dest_write(dest_write)
	);

	fixed_lane_alu alu_i (
		.fx_op(fx_op),
		.elem_size(elem_size),
		.ra(ra),
		.operand_b(operand_b),
		.result(result)
	);

	// two cycles from issue to writeback
	fixed_result_stage stage_i (
		.clk(clk),
		.reset(reset),
		.result(result),
		.dest_addr(dest_addr),
		.dest_write(dest_write),
		.rt_wb(rt_wb),
		.rt_addr_wb(rt_addr_wb),
		.reg_write_wb(reg_write_wb)
	);

endmodule

// File: tb.f
+incdir+.
fixed_pkg.sv
fixed_operand_decode.sv
fixed_lane_alu.sv
fixed_result_stage.sv
simple_fixed_unit.sv
tb_simple_fixed_unit.sv

// File: tb_simple_fixed_unit.sv
`include "fixed_config.svh"

module tb_simple_fixed_unit
	import fixed_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int cycle_limit = 700;

	// kept opcodes, RI10 codes zero-extended into the 11-bit op field
	localparam logic [10:0] rr_ops [17] = '{`FX_OPC_AH, `FX_OPC_A, `FX_OPC_SFH, `FX_OPC_SF,
		`FX_OPC_AND, `FX_OPC_OR, `FX_OPC_XOR, `FX_OPC_NAND, `FX_OPC_CEQB, `FX_OPC_CEQH,
		`FX_OPC_CEQ, `FX_OPC_CGTB, `FX_OPC_CGTH, `FX_OPC_CGT, `FX_OPC_CLGTB, `FX_OPC_CLGTH,
		`FX_OPC_CLGT};
	localparam logic [7:0] ri_ops [19] = '{`FX_OPC_AHI, `FX_OPC_AI, `FX_OPC_SFHI, `FX_OPC_SFI,
		`FX_OPC_ANDHI, `FX_OPC_ANDI, `FX_OPC_ORHI, `FX_OPC_ORI, `FX_OPC_XORHI, `FX_OPC_XORI,
		`FX_OPC_CEQBI, `FX_OPC_CEQHI, `FX_OPC_CEQI, `FX_OPC_CGTBI, `FX_OPC_CGTHI,
		`FX_OPC_CGTI, `FX_OPC_CLGTBI, `FX_OPC_CLGTHI, `FX_OPC_CLGTI};
	// immediates at the sign and byte boundaries
	localparam logic [9:0] imm_edges [8] = '{10'h1ff, 10'h200, 10'h3ff, 10'h000,
		10'h080, 10'h07f, 10'h0ff, 10'h100};

	logic clk;
	logic reset;
	logic [2:0] format;
	logic [10:0] op;
	logic [6:0] rt_addr;
	logic [127:0] ra;
	logic [127:0] rb;
	logic [17:0] imm;
	logic reg_write;
	logic branch_taken;
	logic [127:0] rt_wb;
	logic [6:0] rt_addr_wb;
	logic reg_write_wb;

	logic [31:0] rng_state;
	int errors;
	// squashed slots must request a write so the gating shows
	logic force_write;
	// expectations in flight, oldest first
	logic [127:0] exp_val [$];
	logic [6:0] exp_addr [$];
	logic exp_wr [$];
	string exp_name [$];

	simple_fixed_unit simple_fixed_unit_i (
		.clk(clk), .reset(reset), .format(format), .op(op), .rt_addr(rt_addr),
		.ra(ra), .rb(rb), .imm(imm), .reg_write(reg_write), .branch_taken(branch_taken),
		.rt_wb(rt_wb), .rt_addr_wb(rt_addr_wb), .reg_write_wb(reg_write_wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic logic [127:0] rand_quad();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	// element-wise operation over n-bit elements
	function automatic logic [127:0] elem_ref(fx_op_e kind, int n, logic [127:0] a,
		logic [127:0] b);
		logic [127:0] r;
		logic [127:0] ta;
		logic [127:0] tb;
		longint full;
		longint lim;
		longint ua;
		longint ub;
		longint sa;
		longint sb;
		longint res;

		r = '0;
		full = longint'(1) << n;
		lim = full / 2;
		for (int i = 0; i < 128 / n; i++) begin
			ta = a >> (i * n);
			tb = b >> (i * n);
			ua = ta[31:0] & (full - 1);
			ub = tb[31:0] & (full - 1);
			sa = (ua >= lim) ? ua - full : ua;
			sb = (ub >= lim) ? ub - full : ub;
			case (kind)
				FX_ADD: res = sa + sb;
				FX_SUB_FROM: res = sb - sa;
				FX_AND: res = ua & ub;
				FX_OR: res = ua | ub;
				FX_XOR: res = ua ^ ub;
				FX_NAND: res = ~(ua & ub);
				FX_CEQ: res = (ua == ub) ? full - 1 : 0;
				FX_CGT: res = (sa > sb) ? full - 1 : 0;
				FX_CLGT: res = (ua > ub) ? full - 1 : 0;
				default: res = 0;
			endcase
			// clamp only the arithmetic results
			if (kind == FX_ADD || kind == FX_SUB_FROM) begin
				if (res > lim - 1)
					res = lim - 1;
				if (res < -lim)
					res = -lim;
			end
			res = res & (full - 1);
			r = r | ({64'b0, res} << (i * n));
		end
		return r;
	endfunction

	// expected writeback for one issued slot
	function automatic void ref_model(input logic [2:0] fmt, input logic [10:0] opc,
		input logic [6:0] addr, input logic [127:0] a, input logic [127:0] b,
		input logic [17:0] im, input logic wr, input logic br,
		output logic [127:0] val, output logic [6:0] waddr, output logic wflag);
		fx_op_e kind;
		int n;
		logic [127:0] opb;
		logic [31:0] ext;

		kind = FX_NOP;
		n = 32;
		opb = b;
		if (fmt == 3'd0) begin
			case (opc)
				`FX_OPC_AH: kind = FX_ADD;
				`FX_OPC_A: kind = FX_ADD;
				`FX_OPC_SFH: kind = FX_SUB_FROM;
				`FX_OPC_SF: kind = FX_SUB_FROM;
				`FX_OPC_AND: kind = FX_AND;
				`FX_OPC_OR: kind = FX_OR;
				`FX_OPC_XOR: kind = FX_XOR;
				`FX_OPC_NAND: kind = FX_NAND;
				`FX_OPC_CEQB: kind = FX_CEQ;
				`FX_OPC_CEQH: kind = FX_CEQ;
				`FX_OPC_CEQ: kind = FX_CEQ;
				`FX_OPC_CGTB: kind = FX_CGT;
				`FX_OPC_CGTH: kind = FX_CGT;
				`FX_OPC_CGT: kind = FX_CGT;
				`FX_OPC_CLGTB: kind = FX_CLGT;
				`FX_OPC_CLGTH: kind = FX_CLGT;
				`FX_OPC_CLGT: kind = FX_CLGT;
				default: kind = FX_NOP;
			endcase
			// halfword and byte forms, the rest work on words
			case (opc)
				`FX_OPC_AH, `FX_OPC_SFH: n = 16;
				`FX_OPC_CEQH, `FX_OPC_CGTH, `FX_OPC_CLGTH: n = 16;
				`FX_OPC_CEQB, `FX_OPC_CGTB, `FX_OPC_CLGTB: n = 8;
				default: n = 32;
			endcase
		end else if (fmt == 3'd4 && opc[10:8] == 3'b000) begin
			case (opc[7:0])
				`FX_OPC_AHI: kind = FX_ADD;
				`FX_OPC_AI: kind = FX_ADD;
				`FX_OPC_SFHI: kind = FX_SUB_FROM;
				`FX_OPC_SFI: kind = FX_SUB_FROM;
				`FX_OPC_ANDHI: kind = FX_AND;
				`FX_OPC_ANDI: kind = FX_AND;
				`FX_OPC_ORHI: kind = FX_OR;
				`FX_OPC_ORI: kind = FX_OR;
				`FX_OPC_XORHI: kind = FX_XOR;
				`FX_OPC_XORI: kind = FX_XOR;
				`FX_OPC_CEQBI: kind = FX_CEQ;
				`FX_OPC_CEQHI: kind = FX_CEQ;
				`FX_OPC_CEQI: kind = FX_CEQ;
				`FX_OPC_CGTBI: kind = FX_CGT;
				`FX_OPC_CGTHI: kind = FX_CGT;
				`FX_OPC_CGTI: kind = FX_CGT;
				`FX_OPC_CLGTBI: kind = FX_CLGT;
				`FX_OPC_CLGTHI: kind = FX_CLGT;
				`FX_OPC_CLGTI: kind = FX_CLGT;
				default: kind = FX_NOP;
			endcase
			// halfword and byte forms, the rest work on words
			case (opc[7:0])
				`FX_OPC_AHI, `FX_OPC_SFHI, `FX_OPC_ANDHI, `FX_OPC_ORHI: n = 16;
				`FX_OPC_XORHI, `FX_OPC_CEQHI, `FX_OPC_CGTHI, `FX_OPC_CLGTHI: n = 16;
				`FX_OPC_CEQBI, `FX_OPC_CGTBI, `FX_OPC_CLGTBI: n = 8;
				default: n = 32;
			endcase
			// sign-extend the 10-bit immediate, byte elements keep its low 8 bits
			ext = {{22{im[9]}}, im[9:0]};
			opb = '0;
			for (int i = 0; i < 128 / n; i++)
				opb = opb | ({96'b0, ext & ((32'h1 << n) - 1 | {32{n == 32}})} << (i * n));
		end
		if (kind == FX_NOP || br) begin
			val = '0;
			waddr = '0;
			wflag = 1'b0;
		end else begin
			val = elem_ref(kind, n, a, opb);
			waddr = addr;
			wflag = wr;
		end
	endfunction

	task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
		if (expected !== actual) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// queue the expectation for whatever the inputs hold now
	task automatic record_slot(string name);
		logic [127:0] val;
		logic [6:0] waddr;
		logic wflag;

		ref_model(format, op, rt_addr, ra, rb, imm, reg_write, branch_taken, val, waddr, wflag);
		exp_val.push_back(val);
		exp_addr.push_back(waddr);
		exp_wr.push_back(wflag);
		exp_name.push_back(name);
	endtask

	task automatic issue_slot(string name, logic [2:0] fmt, logic [10:0] opc,
		logic [127:0] a, logic [127:0] b, logic [17:0] im, logic br);
		@(negedge clk);
		format = fmt;
		op = opc;
		rt_addr = 7'(next_rand());
		ra = a;
		rb = b;
		imm = im;
		reg_write = force_write || (next_rand() % 4 != 0);
		branch_taken = br;
		record_slot(name);
	endtask

	// result of slot k shows after the edge following its sample edge
	initial begin
		forever begin
			@(posedge clk);
			#1;
			if (exp_val.size() == 2) begin
				check_value({exp_name[0], " value"}, exp_val.pop_front(), rt_wb);
				check_value({exp_name[0], " addr"}, 128'(exp_addr.pop_front()), 128'(rt_addr_wb));
				check_value({exp_name[0], " write"}, 128'(exp_wr.pop_front()), 128'(reg_write_wb));
				void'(exp_name.pop_front());
			end else begin
				check_value("reset value", '0, rt_wb);
				check_value("reset addr", '0, 128'(rt_addr_wb));
				check_value("reset write", '0, 128'(reg_write_wb));
			end
		end
	end

	initial begin
		int cycles;

		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic [17:0] im;
		logic [10:0] opc;

		rng_state = 32'd61522;
		errors = 0;
		force_write = 1'b0;
		reset = 1'b1;
		format = '0;
		op = '0;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		imm = '0;
		reg_write = 1'b0;
		branch_taken = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		record_slot("reset");
		issue_slot("reset", 3'd0, 11'd0, '0, '0, '0, 1'b0);

		for (int i = 0; i < 200; i++)
			issue_slot("rr random", 3'd0, rr_ops[next_rand() % 17], rand_quad(), rand_quad(),
				'0, 1'b0);

		// saturation corners
		issue_slot("sat ah max+1", 3'd0, `FX_OPC_AH, {8{16'h7fff}}, {8{16'h0001}}, '0, 1'b0);
		issue_slot("sat ah min-1", 3'd0, `FX_OPC_AH, {8{16'h8000}}, {8{16'hffff}}, '0, 1'b0);
		issue_slot("sat a min-1", 3'd0, `FX_OPC_A, {4{32'h80000000}}, {4{32'hffffffff}}, '0, 1'b0);
		issue_slot("sat a mixed", 3'd0, `FX_OPC_A, {4{32'h7fffffff}}, {4{32'h80000000}}, '0, 1'b0);
		issue_slot("sat sfh min-1", 3'd0, `FX_OPC_SFH, {8{16'h0001}}, {8{16'h8000}}, '0, 1'b0);
		issue_slot("sat sfh max+1", 3'd0, `FX_OPC_SFH, {8{16'hffff}}, {8{16'h7fff}}, '0, 1'b0);
		issue_slot("sat sf min-max", 3'd0, `FX_OPC_SF, {4{32'h7fffffff}}, {4{32'h80000000}},
			'0, 1'b0);
		issue_slot("sat sf max-min", 3'd0, `FX_OPC_SF, {4{32'h80000000}}, {4{32'h7fffffff}},
			'0, 1'b0);

		// immediates, weighted toward negative and edge values
		for (int i = 0; i < 200; i++) begin
			case (next_rand() % 4)
				0: im = {8'h00, 1'b1, 9'(next_rand())};
				1: im = {8'h00, imm_edges[next_rand() % 8]};
				default: im = 18'(next_rand());
			endcase
			issue_slot("ri10 random", 3'd4, {3'b000, ri_ops[next_rand() % 19]}, rand_quad(),
				rand_quad(), im, 1'b0);
		end

		// squashed slots with valid work around them
		force_write = 1'b1;
		issue_slot("squash nop", 3'd0, 11'd0, rand_quad(), rand_quad(), '0, 1'b0);
		issue_slot("squash around", 3'd0, `FX_OPC_A, rand_quad(), rand_quad(), '0, 1'b0);
		issue_slot("squash branch", 3'd0, `FX_OPC_AH, rand_quad(), rand_quad(), '0, 1'b1);
		issue_slot("squash around", 3'd4, {3'b000, `FX_OPC_ORI}, rand_quad(), '0, 18'h3ff, 1'b0);
		issue_slot("squash bad rr op", 3'd0, 11'h7ff, rand_quad(), rand_quad(), '0, 1'b0);
		issue_slot("squash bad ri op", 3'd4, 11'h0ff, rand_quad(), '0, 18'h155, 1'b0);
		opc = {3'b101, `FX_OPC_AI};
		issue_slot("squash ri upper op", 3'd4, opc, rand_quad(), '0, 18'h001, 1'b0);
		issue_slot("squash format", 3'd2, `FX_OPC_A, rand_quad(), rand_quad(), '0, 1'b0);
		issue_slot("squash around", 3'd0, `FX_OPC_XOR, rand_quad(), rand_quad(), '0, 1'b0);
		force_write = 1'b0;

		// drain the pipe
		repeat (3)
			issue_slot("drain", 3'd0, 11'd0, '0, '0, '0, 1'b0);
		@(posedge clk);
		#2;
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
